// File: hw/poly_pkg.sv
package poly_pkg;

  // **************************************************
  // basic widths
  // **************************************************

  // one spi data byte
  typedef logic [7:0] byte_t;
  // spi bus address, upper 16 bits select the window
  typedef logic [31:0] bus_addr_t;
  // one point buffer word
  typedef logic [15:0] word_t;
  // unsigned pixel coordinate
  typedef logic [15:0] coord_t;
  // rgb565 pixel colour
  typedef logic [15:0] color_t;
  // polyline length in bytes, 4 bytes per point
  typedef logic [15:0] len_t;

  // **************************************************
  // grouped signals
  // **************************************************

  // payload of one bus write strobe
  typedef struct packed {
    bus_addr_t addr;
    byte_t     data;
  } bus_wr_t;

  // one pixel, or one segment end point
  typedef struct packed {
    coord_t x;
    coord_t y;
    color_t color;
  } pixel_t;

  // address windows, upper 16 address bits
  localparam logic [15:0] BUF_WINDOW = 16'h1cdd;
  localparam logic [15:0] CMD_WINDOW = 16'h1cde;

endpackage

// File: hw/spi_write_slave.sv
`timescale 1ns/1ps

module spi_write_slave (
  input  logic              clk,
  input  logic              rst,
  input  logic              csn,
  input  logic              sclk,
  input  logic              mosi,
  output logic              bus_wr,
  output poly_pkg::bus_wr_t bus
);
  import poly_pkg::*;

  // synchronizer stages, bit order {csn, sclk, mosi}
  logic [2:0] sync_a;
  logic [2:0] sync_b;
  logic       csn_s;
  logic       sclk_s;
  logic       mosi_s;
  // sclk edge detect
  logic       sclk_prev;
  logic       sclk_rise;
  // byte assembly
  logic [2:0] bit_cnt;
  logic [6:0] shift;
  byte_t      rx_byte;
  logic       byte_done;
  // address phase, bit 2 set once four bytes are in
  logic [2:0] addr_cnt;
  bus_addr_t  addr;

  assign csn_s  = sync_b[2];
  assign sclk_s = sync_b[1];
  assign mosi_s = sync_b[0];

  // mode 0, sample on rising sclk
  assign sclk_rise = sclk_s & ~sclk_prev;
  // eighth bit comes straight from the pin
  assign rx_byte   = {shift, mosi_s};
  assign byte_done = ~csn_s & sclk_rise & (bit_cnt == 3'd7);

  // csn idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_a    <= 3'b100;
      sync_b    <= 3'b100;
      sclk_prev <= 1'b0;
    end else begin
      sync_a    <= {csn, sclk, mosi};
      sync_b    <= sync_a;
      sclk_prev <= sclk_s;
    end
  end

  // msb first, older bits fall out after a byte
  always_ff @(posedge clk) begin
    if (sclk_rise) begin
      shift <= {shift[5:0], mosi_s};
    end
  end

  // bit and address phase counters, csn high drops a partial byte
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      addr_cnt <= '0;
      bus_wr   <= 1'b0;
    end else begin
      bus_wr <= 1'b0;
      if (csn_s) begin
        bit_cnt  <= '0;
        addr_cnt <= '0;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (byte_done) begin
          if (!addr_cnt[2]) addr_cnt <= addr_cnt + 3'd1;
          else bus_wr <= 1'b1;
        end
      end
    end
  end

  // big-endian address, then one write per byte
  always_ff @(posedge clk) begin
    if (byte_done) begin
      if (!addr_cnt[2]) begin
        addr <= {addr[23:0], rx_byte};
      end else begin
        bus.addr <= addr;
        bus.data <= rx_byte;
        // next byte goes to the following address
        addr     <= addr + 32'd1;
      end
    end
  end

endmodule

// File: hw/poly_regs.sv
`timescale 1ns/1ps

module poly_regs #(
  parameter int buf_addr_bits = 10
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     bus_wr,
  input  poly_pkg::bus_wr_t        bus,
  input  logic [buf_addr_bits-1:0] rd_addr,
  output poly_pkg::word_t          rd_data,
  output poly_pkg::color_t         color,
  output poly_pkg::len_t           len,
  output logic                     plot
);
  import poly_pkg::*;

  // point buffer, x0 y0 x1 y1 ...
  word_t                    mem [0:(1 << buf_addr_bits) - 1];
  // even byte waits here for its partner
  byte_t                    msb_hold;
  logic                     buf_sel;
  logic                     cmd_sel;
  logic [buf_addr_bits-1:0] wr_addr;

  // **************************************************
  // window decode
  // **************************************************

  assign buf_sel = bus_wr & (bus.addr[31:16] == BUF_WINDOW);
  assign cmd_sel = bus_wr & (bus.addr[31:16] == CMD_WINDOW);
  // byte address to word address
  assign wr_addr = bus.addr[buf_addr_bits:1];

  // **************************************************
  // point buffer
  // **************************************************

  // even address holds msb
  always_ff @(posedge clk) begin
    if (buf_sel && !bus.addr[0]) begin
      msb_hold <= bus.data;
    end
  end

  // odd address commits the whole word
  always_ff @(posedge clk) begin
    if (buf_sel && bus.addr[0]) begin
      mem[wr_addr] <= {msb_hold, bus.data};
    end
  end

  // synchronous read, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // **************************************************
  // command registers
  // **************************************************

  // offsets 0..3: colour msb, colour lsb, len msb, len lsb
  always_ff @(posedge clk) begin
    if (rst) begin
      color <= '0;
      len   <= '0;
      plot  <= 1'b0;
    end else begin
      plot <= 1'b0;
      if (cmd_sel) begin
        case (bus.addr[1:0])
          2'd0: color[15:8] <= bus.data;
          2'd1: color[7:0]  <= bus.data;
          2'd2: len[15:8]   <= bus.data;
          default: begin
            len[7:0] <= bus.data;
            // len lsb also kicks off the plot
            plot     <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

// File: hw/line_stepper.sv
`timescale 1ns/1ps

module line_stepper (
  input  logic             clk,
  input  logic             rst,
  input  logic             seg_start,
  input  logic             skip_first,
  input  poly_pkg::pixel_t seg_from,
  input  poly_pkg::pixel_t seg_to,
  output logic             pixel_valid,
  output poly_pkg::pixel_t pixel,
  output logic             seg_done
);
  import poly_pkg::*;

  // current point and end point
  coord_t             x;
  coord_t             y;
  coord_t             x_end;
  coord_t             y_end;
  color_t             col;
  // step directions where all ones is minus one
  coord_t             sx;
  coord_t             sy;
  // bresenham terms with dy kept negative
  logic signed [17:0] err;
  logic signed [17:0] dx;
  logic signed [17:0] dy;
  logic               running;
  logic               skip;
  // setup values from the segment ports
  coord_t             adx;
  coord_t             ady;
  logic signed [17:0] dx_init;
  logic signed [17:0] dy_init;
  // one step
  logic signed [18:0] e2;
  logic               step_x;
  logic               step_y;
  logic               at_end;
  logic signed [17:0] err_next;

  // **************************************************
  // segment setup
  // **************************************************

  always_comb begin
    adx = (seg_to.x >= seg_from.x) ? seg_to.x - seg_from.x : seg_from.x - seg_to.x;
    ady = (seg_to.y >= seg_from.y) ? seg_to.y - seg_from.y : seg_from.y - seg_to.y;
    dx_init = signed'({2'b00, adx});
    dy_init = -signed'({2'b00, ady});
  end

  // **************************************************
  // step logic
  // **************************************************

  always_comb begin
    e2       = {err, 1'b0};
    step_x   = (e2 >= 19'(dy));
    step_y   = (e2 <= 19'(dx));
    // both moves can happen in one step
    err_next = err + (step_x ? dy : 18'sd0) + (step_y ? dx : 18'sd0);
    at_end   = (x == x_end) && (y == y_end);
  end

  // current point leaves every running cycle
  assign pixel_valid = running & ~skip;
  assign pixel       = '{x: x, y: y, color: col};
  // last point of the segment even when suppressed
  assign seg_done    = running & at_end;

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      skip    <= 1'b0;
    end else if (seg_start) begin
      running <= 1'b1;
      skip    <= skip_first;
    end else if (running) begin
      // only the first point can be skipped
      skip <= 1'b0;
      if (at_end) running <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (seg_start) begin
      x     <= seg_from.x;
      y     <= seg_from.y;
      x_end <= seg_to.x;
      y_end <= seg_to.y;
      col   <= seg_from.color;
      sx    <= (seg_to.x >= seg_from.x) ? 16'h0001 : 16'hffff;
      sy    <= (seg_to.y >= seg_from.y) ? 16'h0001 : 16'hffff;
      dx    <= dx_init;
      dy    <= dy_init;
      err   <= dx_init + dy_init;
    end else if (running && !at_end) begin
      if (step_x) x <= x + sx;
      if (step_y) y <= y + sy;
      err <= err_next;
    end
  end

endmodule

// File: hw/polyline_seq.sv
`timescale 1ns/1ps

module polyline_seq #(
  parameter int buf_addr_bits = 10
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     plot,
  input  poly_pkg::len_t           len,
  input  poly_pkg::color_t         color,
  output logic [buf_addr_bits-1:0] rd_addr,
  input  poly_pkg::word_t          rd_data,
  output logic                     seg_start,
  output poly_pkg::pixel_t         seg_from,
  output poly_pkg::pixel_t         seg_to,
  output logic                     skip_first,
  input  logic                     seg_done,
  output logic                     busy
);
  import poly_pkg::*;

  typedef enum logic [1:0] {st_idle, st_fetch, st_load, st_draw} state_t;

  state_t      state;
  // fetch cycle, 0 read x, 1 read y, 2 capture y
  logic [1:0]  fc;
  // point count and next point to fetch
  logic [13:0] count;
  logic [13:0] pt_idx;
  // set until the first segment is loaded
  logic        first;
  color_t      col_q;
  coord_t      nx;

  assign busy       = (state != st_idle);
  assign seg_start  = (state == st_load);
  // shared vertex was the previous segment's end
  assign skip_first = ~first;
  // point i lives at words 2i and 2i+1
  assign rd_addr    = {pt_idx[buf_addr_bits-2:0], fc[0]};

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      fc     <= '0;
      count  <= '0;
      pt_idx <= '0;
      first  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // plot while busy never reaches here
          if (plot) begin
            state  <= st_fetch;
            fc     <= '0;
            pt_idx <= '0;
            count  <= len[15:2];
            first  <= 1'b1;
          end
        end
        st_fetch: begin
          fc <= fc + 2'd1;
          if (fc == 2'd1 && count < 14'd2) begin
            // nothing to draw
            state <= st_idle;
          end else if (fc == 2'd2) begin
            fc     <= '0;
            pt_idx <= pt_idx + 14'd1;
            // first segment needs two points
            if (pt_idx != 14'd0) state <= st_load;
          end
        end
        st_load: begin
          first <= 1'b0;
          state <= st_draw;
        end
        default: begin
          if (seg_done) begin
            if (pt_idx == count) state <= st_idle;
            else state <= st_fetch;
          end
        end
      endcase
    end
  end

  // end points shift along the list
  always_ff @(posedge clk) begin
    if (state == st_idle && plot) begin
      col_q <= color;
    end
    if (state == st_fetch && fc == 2'd1) begin
      nx <= rd_data;
    end
    if (state == st_fetch && fc == 2'd2) begin
      seg_from <= seg_to;
      seg_to   <= '{x: nx, y: rd_data, color: col_q};
    end
  end

endmodule

// File: hw/poly_top.sv
`timescale 1ns/1ps

module poly_top #(
  parameter int buf_addr_bits = 10
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             csn,
  input  logic             sclk,
  input  logic             mosi,
  output logic             busy,
  output logic             pixel_valid,
  output poly_pkg::pixel_t pixel
);
  import poly_pkg::*;

  // spi to register bus
  logic                     bus_wr;
  bus_wr_t                  bus;
  // buffer read port
  logic [buf_addr_bits-1:0] rd_addr;
  word_t                    rd_data;
  // command registers
  color_t                   color;
  len_t                     len;
  logic                     plot;
  // segment handshake
  logic                     seg_start;
  pixel_t                   seg_from;
  pixel_t                   seg_to;
  logic                     skip_first;
  logic                     seg_done;

  spi_write_slave spi_write_slave_inst (
    .clk    (clk),
    .rst    (rst),
    .csn    (csn),
    .sclk   (sclk),
    .mosi   (mosi),
    .bus_wr (bus_wr),
    .bus    (bus)
  );

  poly_regs #(
    .buf_addr_bits (buf_addr_bits)
  ) poly_regs_inst (
    .clk     (clk),
    .rst     (rst),
    .bus_wr  (bus_wr),
    .bus     (bus),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .color   (color),
    .len     (len),
    .plot    (plot)
  );

  polyline_seq #(
    .buf_addr_bits (buf_addr_bits)
  ) polyline_seq_inst (
    .clk        (clk),
    .rst        (rst),
    .plot       (plot),
    .len        (len),
    .color      (color),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .seg_start  (seg_start),
    .seg_from   (seg_from),
    .seg_to     (seg_to),
    .skip_first (skip_first),
    .seg_done   (seg_done),
    .busy       (busy)
  );

  line_stepper line_stepper_inst (
    .clk         (clk),
    .rst         (rst),
    .seg_start   (seg_start),
    .skip_first  (skip_first),
    .seg_from    (seg_from),
    .seg_to      (seg_to),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .seg_done    (seg_done)
  );

endmodule

// File: test/poly_sva.sv
`timescale 1ns/1ps

module poly_sva (
  input logic clk,
  input logic rst,
  input logic plot,
  input logic busy,
  input logic pixel_valid
);

  // **************************************************
  // top level port properties
  // **************************************************

  // pixels only inside a plot
  property pixel_within_busy;
    @(posedge clk) disable iff (rst) pixel_valid |-> busy;
  endproperty

  // sequencer comes out of reset idle
  property idle_after_reset;
    @(posedge clk) rst |=> !busy;
  endproperty

  // accepted plot shows up as busy one cycle later
  property busy_after_plot;
    @(posedge clk) disable iff (rst) (plot && !busy) |=> busy;
  endproperty

  property pixel_valid_known;
    @(posedge clk) disable iff (rst) !$isunknown(pixel_valid);
  endproperty

  assert property (pixel_within_busy) else $error("pixel_valid high while busy is low");
  assert property (idle_after_reset) else $error("busy high right after reset");
  assert property (busy_after_plot) else $error("busy did not rise after an idle plot");
  assert property (pixel_valid_known) else $error("pixel_valid is unknown");

endmodule

bind poly_top poly_sva poly_sva_inst (
  .clk         (clk),
  .rst         (rst),
  .plot        (plot),
  .busy        (busy),
  .pixel_valid (pixel_valid)
);

// File: test/tb_poly_top.sv
`timescale 1ns/1ps

module tb_poly_top;
  import poly_pkg::*;

  localparam int NROWS = 18;

  // one table row with up to six points
  typedef struct packed {
    logic [2:0]   npts;
    coord_t [5:0] px;
    coord_t [5:0] py;
    color_t       color;
    len_t         len;
    // flag bit 0 adds junk writes first
    // flag bit 1 sends a second plot while busy
    logic [1:0]   flags;
  } row_t;

  logic   clk;
  logic   rst;
  logic   csn;
  logic   sclk;
  logic   mosi;
  logic   busy;
  logic   pixel_valid;
  pixel_t pixel;

  row_t   rows [NROWS];
  int     nrows = 0;
  int     pcnt = 0;
  byte_t  tx_q [$];
  pixel_t expected_q [$];
  pixel_t actual_q [$];
  logic   busy_seen = 1'b0;
  int     errors = 0;
  int     cycles = 0;
  int     limit = 0;

  poly_top #(
    .buf_addr_bits (10)
  ) poly_top_inst (
    .clk         (clk),
    .rst         (rst),
    .csn         (csn),
    .sclk        (sclk),
    .mosi        (mosi),
    .busy        (busy),
    .pixel_valid (pixel_valid),
    .pixel       (pixel)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // pixel strobes and busy collected mid cycle
  always @(negedge clk) begin
    if (pixel_valid === 1'b1) actual_q.push_back(pixel);
    if (busy === 1'b1) busy_seen = 1'b1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the plotter never went idle", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // **************************************************
  // spi bit-bang
  // **************************************************

  // lands 2 ns after a rising edge
  task automatic tick(int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // mode 0 msb first with 3 cycles per sclk level
  task automatic spi_byte(byte_t b);
    int i;
    for (i = 7; i >= 0; i--) begin
      sclk = 1'b0;
      mosi = b[i];
      tick(3);
      sclk = 1'b1;
      tick(3);
    end
  endtask

  // address then whatever sits in tx_q
  task automatic spi_burst(bus_addr_t addr);
    int i;
    csn = 1'b0;
    tick(3);
    spi_byte(addr[31:24]);
    spi_byte(addr[23:16]);
    spi_byte(addr[15:8]);
    spi_byte(addr[7:0]);
    for (i = 0; i < tx_q.size(); i++) spi_byte(tx_q[i]);
    sclk = 1'b0;
    tick(3);
    csn = 1'b1;
    tick(4);
    tx_q.delete();
  endtask

  // **************************************************
  // table and reference
  // **************************************************

  task automatic new_row(int n, int color, int len, int flags);
    rows[nrows].npts  = 3'(n);
    rows[nrows].px    = '0;
    rows[nrows].py    = '0;
    rows[nrows].color = 16'(color);
    rows[nrows].len   = 16'(len);
    rows[nrows].flags = 2'(flags);
    nrows++;
    pcnt = 0;
  endtask

  task automatic point(int x, int y);
    rows[nrows - 1].px[pcnt] = 16'(x);
    rows[nrows - 1].py[pcnt] = 16'(y);
    pcnt++;
  endtask

  task automatic build_table();
    int i;
    int j;
    int n;
    new_row(2, 'hf800, 8, 0);
    point(10, 20);
    point(25, 20);
    new_row(2, 'h07e0, 8, 0);
    point(40, 50);
    point(40, 30);
    // closed shallow diamond
    new_row(5, 'h001f, 20, 0);
    point(100, 100);
    point(130, 110);
    point(100, 120);
    point(70, 110);
    point(100, 100);
    // closed steep diamond
    new_row(5, 'hffe0, 20, 0);
    point(160, 100);
    point(170, 130);
    point(160, 160);
    point(150, 130);
    point(160, 100);
    new_row(5, 'h1234, 20, 0);
    point(5, 5);
    point(50, 17);
    point(12, 60);
    point(200, 61);
    point(199, 230);
    new_row(3, 'habcd, 12, 1);
    point(30, 200);
    point(60, 180);
    point(45, 150);
    // one point only
    new_row(2, 'hffff, 4, 0);
    point(0, 0);
    point(9, 9);
    // long line leaves room for a second plot
    new_row(2, 'h8410, 8, 2);
    point(0, 5);
    point(600, 5);
    for (i = 0; i < 10; i++) begin
      n = 2 + int'($urandom % 5);
      new_row(n, int'($urandom & 32'hffff), 4 * n, 0);
      for (j = 0; j < n; j++) point(int'($urandom % 240), int'($urandom % 240));
    end
  endtask

  // spi bytes at 48 cycles each plus one cycle per pixel
  function automatic int row_cycles(row_t r);
    int c;
    int i;
    int a;
    int b;
    c = 48 * (12 + 4 * int'(r.npts)) + 40;
    if (r.flags[0]) c = c + 48 * 18 + 40;
    if (r.flags[1]) c = c + 48 * 5 + 20;
    for (i = 0; i + 1 < int'(r.npts); i++) begin
      a = int'(r.px[i]) - int'(r.px[i + 1]);
      b = int'(r.py[i]) - int'(r.py[i + 1]);
      if (a < 0) a = -a;
      if (b < 0) b = -b;
      c = c + ((a > b) ? a : b) + 10;
    end
    return c;
  endfunction

  // bresenham walk with err tracked in plain ints
  task automatic draw_reference(int x0, int y0, int x1, int y1, bit skip, color_t c);
    int     x;
    int     y;
    int     dx;
    int     dy;
    int     sx;
    int     sy;
    int     err;
    int     e2;
    bit     first;
    bit     done;
    pixel_t p;
    x     = x0;
    y     = y0;
    dx    = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy    = (y1 > y0) ? y0 - y1 : y1 - y0;
    sx    = (x1 >= x0) ? 1 : -1;
    sy    = (y1 >= y0) ? 1 : -1;
    err   = dx + dy;
    first = 1'b1;
    done  = 1'b0;
    while (!done) begin
      if (!(skip && first)) begin
        p.x     = 16'(x);
        p.y     = 16'(y);
        p.color = c;
        expected_q.push_back(p);
      end
      if (x == x1 && y == y1) begin
        done = 1'b1;
      end else begin
        e2 = 2 * err;
        if (e2 >= dy) begin
          err = err + dy;
          x   = x + sx;
        end
        if (e2 <= dx) begin
          err = err + dx;
          y   = y + sy;
        end
      end
      first = 1'b0;
    end
  endtask

  // shared vertices drop out after the first segment
  task automatic build_expected(row_t row);
    int cnt;
    int i;
    expected_q.delete();
    cnt = int'(row.len >> 2);
    for (i = 0; i + 1 < cnt; i++) begin
      draw_reference(int'(row.px[i]), int'(row.py[i]), int'(row.px[i + 1]),
                     int'(row.py[i + 1]), i > 0, row.color);
    end
  endtask

  // **************************************************
  // checks and row runner
  // **************************************************

  task automatic check_value(string name, logic [15:0] actual, logic [15:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic compare_pixels(int r);
    int i;
    for (i = 0; i < expected_q.size() && i < actual_q.size(); i++) begin
      check_value($sformatf("pixel.x row %0d index %0d", r, i),
                  actual_q[i].x, expected_q[i].x);
      check_value($sformatf("pixel.y row %0d index %0d", r, i),
                  actual_q[i].y, expected_q[i].y);
      check_value($sformatf("pixel.color row %0d index %0d", r, i),
                  actual_q[i].color, expected_q[i].color);
    end
    if (expected_q.size() > actual_q.size()) begin
      errors++;
      $display("row %0d: missing pixels, %0d expected but only %0d seen",
               r, expected_q.size(), actual_q.size());
    end else if (actual_q.size() > expected_q.size()) begin
      errors++;
      $display("row %0d: extra pixels, %0d expected but %0d seen",
               r, expected_q.size(), actual_q.size());
    end
  endtask

  task automatic run_row(int r);
    row_t row;
    int   i;
    row = rows[r];
    actual_q.delete();
    build_expected(row);
    if (row.flags[0]) begin
      // outside both windows
      tx_q.push_back(8'h12);
      tx_q.push_back(8'h34);
      tx_q.push_back(8'h56);
      tx_q.push_back(8'h78);
      spi_burst(32'h1cdc_0000);
      tx_q.push_back(8'h01);
      spi_burst(32'h1cdf_0003);
      // lone msb that the full pair below replaces
      tx_q.push_back(8'hab);
      spi_burst({BUF_WINDOW, 16'h0000});
    end
    for (i = 0; i < int'(row.npts); i++) begin
      tx_q.push_back(row.px[i][15:8]);
      tx_q.push_back(row.px[i][7:0]);
      tx_q.push_back(row.py[i][15:8]);
      tx_q.push_back(row.py[i][7:0]);
    end
    spi_burst({BUF_WINDOW, 16'h0000});
    tx_q.push_back(row.color[15:8]);
    tx_q.push_back(row.color[7:0]);
    tx_q.push_back(row.len[15:8]);
    tx_q.push_back(row.len[7:0]);
    busy_seen = 1'b0;
    spi_burst({CMD_WINDOW, 16'h0000});
    // a short plot may be over already
    while (!busy_seen) tick(1);
    if (row.flags[1]) begin
      // len lsb alone restarts a plot when idle
      tx_q.push_back(row.len[7:0]);
      spi_burst({CMD_WINDOW, 16'h0003});
      if (!busy) begin
        errors++;
        $display("row %0d: drawing ended before the second plot went out", r);
      end
    end
    while (busy) tick(1);
    tick(5);
    compare_pixels(r);
  endtask

  initial begin
    int r;
    rst  = 1'b1;
    csn  = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    void'($urandom(1572));
    build_table();
    for (r = 0; r < nrows; r++) limit = limit + row_cycles(rows[r]);
    limit = 2 * (limit + 20);
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    tick(5);
    for (r = 0; r < nrows; r++) run_row(r);
    $display("rows run: %0d, errors: %0d", nrows, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/poly_pkg.sv
hw/spi_write_slave.sv
hw/poly_regs.sv
hw/line_stepper.sv
hw/polyline_seq.sv
hw/poly_top.sv
test/poly_sva.sv
test/tb_poly_top.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_poly_top -f sim.f
	./obj_dir/Vtb_poly_top | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG) || (echo "see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
